/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - logic

sources:
  - logic/dcache_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/dcache_tag_if.sv
  - logic/dcache_data_if.sv
  - logic/dcache_tag_store.sv
  - logic/dcache_data_array.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/mem_model.sv
      - dv/tb_dcache.sv

/* dv/clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock source
// free-running, 4 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk_o
);

  localparam realtime half_period = 2.0; // ns

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* dv/mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory responder for the dcache testbench
// word storage with a fill pattern,
// random 0-3 cycle handshake delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module mem_model import mem_bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,
  input  wire addr_t ar_addr_i,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  output word_t      r_data_o,
  output resp_t      r_resp_o,
  input  wire logic  aw_valid_i,
  output logic       aw_ready_o,
  input  wire addr_t aw_addr_i,
  input  wire logic  w_valid_i,
  output logic       w_ready_o,
  input  wire word_t w_data_i,
  output logic       b_valid_o,
  input  wire logic  b_ready_i,
  output resp_t      b_resp_o
);

  word_t mem_q [addr_t]; // only written words are stored
  addr_t addr;

  // initial content, a function of the whole word address
  function automatic word_t fill_word(addr_t a);
    return {a ^ 32'hc0de_5a5a, {a[15:0], a[31:16]} + 32'h1357_9bdf};
  endfunction

  task automatic random_wait();
    repeat ($urandom_range(3, 0)) @(negedge clk);
  endtask

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = `DCACHE_RESP_OKAY;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    b_resp_o   = `DCACHE_RESP_OKAY;
    forever begin
      @(posedge clk);
      if (!rst && ar_valid_i) begin
        @(negedge clk);
        random_wait();
        ar_ready_o = 1'b1;
        @(posedge clk); // valid is held, so this edge transfers
        addr = ar_addr_i;
        @(negedge clk);
        ar_ready_o = 1'b0;
        random_wait();
        r_valid_o = 1'b1;
        r_data_o  = mem_q.exists(addr) ? mem_q[addr] : fill_word(addr);
        do @(posedge clk); while (!r_ready_i);
        @(negedge clk);
        r_valid_o = 1'b0;
      end else if (!rst && aw_valid_i) begin
        @(negedge clk);
        random_wait();
        aw_ready_o = 1'b1;
        @(posedge clk);
        addr = aw_addr_i;
        @(negedge clk);
        aw_ready_o = 1'b0;
        random_wait();
        w_ready_o = 1'b1;
        do @(posedge clk); while (!w_valid_i);
        mem_q[addr] = w_data_i; // strobe is always full
        @(negedge clk);
        w_ready_o = 1'b0;
        random_wait();
        b_valid_o = 1'b1;
        do @(posedge clk); while (!b_ready_i);
        @(negedge clk);
        b_valid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_dcache.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache testbench
// directed and random loads and stores,
// golden word map, concurrent checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache import mem_bus_pkg::*; ();

  localparam int random_ops = 300;
  localparam int max_cycles = 20000; // 320 ops x 60 cycles worst case, plus margin

  logic  clk, rst;
  logic  ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic  aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  addr_t ar_addr_i, aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  word_t r_data_o, w_data_i, mem_r_data_i, mem_w_data_o;
  resp_t r_resp_o, b_resp_o, mem_r_resp_i, mem_b_resp_i;
  strb_t w_strb_i, mem_w_strb_o;
  logic  mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic  mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic  mem_b_valid_i, mem_b_ready_o;

  word_t golden [addr_t];
  word_t exp_r_data, exp_wb_data;
  logic  expect_hit, last_was_read;
  addr_t last_read_addr;
  int    cycles = 0;

  clk_gen u_clk_gen (.clk_o(clk));

  dcache_top UUT (.*);

  mem_model u_mem (
    .clk        (clk),            .rst       (rst),
    .ar_valid_i (mem_ar_valid_o), .ar_ready_o(mem_ar_ready_i), .ar_addr_i(mem_ar_addr_o),
    .r_valid_o  (mem_r_valid_i),  .r_ready_i (mem_r_ready_o),
    .r_data_o   (mem_r_data_i),   .r_resp_o  (mem_r_resp_i),
    .aw_valid_i (mem_aw_valid_o), .aw_ready_o(mem_aw_ready_i), .aw_addr_i(mem_aw_addr_o),
    .w_valid_i  (mem_w_valid_o),  .w_ready_o (mem_w_ready_i),  .w_data_i (mem_w_data_o),
    .b_valid_o  (mem_b_valid_i),  .b_ready_i (mem_b_ready_o),  .b_resp_o (mem_b_resp_i)
  );

  function automatic word_t fill_word(addr_t a);
    return {a ^ 32'hc0de_5a5a, {a[15:0], a[31:16]} + 32'h1357_9bdf};
  endfunction

  function automatic word_t golden_word(addr_t a);
    addr_t wa;
    wa = {a[31:3], 3'b000};
    return golden.exists(wa) ? golden[wa] : fill_word(wa);
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // 4 tags x 4 indices, so sets conflict and dirty lines get evicted
  function automatic addr_t random_addr();
    logic [`DCACHE_TAG_W-1:0]   tag;
    logic [`DCACHE_INDEX_W-1:0] index;
    tag   = 23'h2a5c1 + 23'($urandom_range(3, 0)) * 23'h10307;
    index = 6'd9 + 6'($urandom_range(3, 0)) * 6'd17;
    return {tag, index, 3'($urandom_range(7, 0))};
  endfunction

  task automatic stop_on_error(string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the cache did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $fatal(1, "run timed out");
    end
  end

  // expected victim word, stable while the write-back runs
  always @(negedge clk) begin
    if (mem_aw_valid_o || mem_w_valid_o) exp_wb_data = golden_word(mem_aw_addr_o);
  end

  assert property (@(posedge clk) rst |=> ar_ready_o && aw_ready_o && !r_valid_o
      && !b_valid_o && !w_ready_o && !mem_ar_valid_o && !mem_aw_valid_o
      && !mem_w_valid_o && !mem_r_ready_o && !mem_b_ready_o)
    else stop_on_error("outputs differ from their reset values");
  assert property (@(posedge clk) disable iff (rst) r_valid_o && r_ready_i
      |-> r_data_o == exp_r_data && r_resp_o == `DCACHE_RESP_OKAY)
    else stop_on_error($sformatf("read got %h, expected %h", r_data_o, exp_r_data));
  assert property (@(posedge clk) disable iff (rst) b_valid_o && b_ready_i
      |-> b_resp_o == `DCACHE_RESP_OKAY)
    else stop_on_error("write response is not OKAY");
  assert property (@(posedge clk) disable iff (rst) ar_valid_i && ar_ready_o && expect_hit
      |=> (!r_valid_o && !mem_ar_valid_o) ##1 (!r_valid_o && !mem_ar_valid_o) ##1 r_valid_o)
    else stop_on_error("repeated read did not hit in 2 cycles");
  assert property (@(posedge clk) disable iff (rst) mem_ar_valid_o |-> mem_ar_addr_o[2:0] == 3'b0)
    else stop_on_error("memory read address not word aligned");
  assert property (@(posedge clk) disable iff (rst) mem_aw_valid_o |-> mem_aw_addr_o[2:0] == 3'b0)
    else stop_on_error("memory write address not word aligned");
  assert property (@(posedge clk) disable iff (rst) mem_w_valid_o && mem_w_ready_i
      |-> mem_w_strb_o == '1 && mem_w_data_o == exp_wb_data)
    else stop_on_error($sformatf("write-back got %h, expected %h", mem_w_data_o, exp_wb_data));
  assert property (@(posedge clk) disable iff (rst) r_valid_o && !r_ready_i
      |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else stop_on_error("read response changed while stalled");
  assert property (@(posedge clk) disable iff (rst) b_valid_o && !b_ready_i
      |=> b_valid_o && $stable(b_resp_o))
    else stop_on_error("write response changed while stalled");
  assert property (@(posedge clk) disable iff (rst) r_valid_o || b_valid_o
      |-> !ar_ready_o && !aw_ready_o)
    else stop_on_error("new request accepted during a pending response");

  task automatic take_response(logic is_write);
    repeat ($urandom_range(6, 0)) @(negedge clk); // ready low for a random stretch
    if (is_write) b_ready_i = 1'b1;
    else r_ready_i = 1'b1;
    do @(posedge clk); while (!(is_write ? b_valid_o : r_valid_o));
    @(negedge clk);
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
  endtask

  task automatic do_read(addr_t addr);
    expect_hit = last_was_read && (addr[31:3] == last_read_addr[31:3]);
    exp_r_data = golden_word(addr);
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    do @(posedge clk); while (!ar_ready_o);
    @(negedge clk);
    ar_valid_i = 1'b0;
    expect_hit = 1'b0;
    take_response(1'b0);
    last_was_read  = 1'b1;
    last_read_addr = addr;
  endtask

  task automatic do_write(addr_t addr, word_t wdata, strb_t strb);
    aw_addr_i  = addr;
    aw_valid_i = 1'b1;
    do @(posedge clk); while (!aw_ready_o);
    @(negedge clk);
    aw_valid_i = 1'b0;
    w_data_i   = wdata;
    w_strb_i   = strb;
    w_valid_i  = 1'b1;
    do @(posedge clk); while (!w_ready_o);
    golden[{addr[31:3], 3'b000}] = merge_bytes(golden_word(addr), wdata, strb);
    @(negedge clk);
    w_valid_i = 1'b0;
    take_response(1'b1);
    last_was_read = 1'b0;
  endtask

  initial begin
    void'($urandom(4));
    rst            = 1'b1;
    ar_valid_i     = 1'b0;
    ar_addr_i      = '0;
    r_ready_i      = 1'b0;
    aw_valid_i     = 1'b0;
    aw_addr_i      = '0;
    w_valid_i      = 1'b0;
    w_data_i       = '0;
    w_strb_i       = '0;
    b_ready_i      = 1'b0;
    expect_hit     = 1'b0;
    last_was_read  = 1'b0;
    last_read_addr = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    do_read({23'h100, 6'd3, 3'd0}); // clean miss
    do_read({23'h100, 6'd3, 3'd4}); // same word, hit
    do_write({23'h100, 6'd3, 3'd0}, 64'h1122_3344_5566_7788, 8'h0f);
    do_read({23'h100, 6'd3, 3'd0});
    do_write({23'h200, 6'd3, 3'd0}, 64'hdead_beef_0bad_f00d, 8'hff); // write miss, other way
    for (int t = 3; t < 6; t++) begin
      do_read({23'(t * 'h100), 6'd3, 3'd0}); // conflicts push out the dirty lines
    end
    do_read({23'h100, 6'd3, 3'd0});
    do_read({23'h200, 6'd3, 3'd0});

    for (int i = 0; i < random_ops; i++) begin
      if ($urandom_range(1, 0) == 1) do_read(random_addr());
      else do_write(random_addr(), {$urandom, $urandom}, 8'($urandom_range(255, 0)));
    end

    repeat (4) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache controller
// blocking FSM for lookup, write-back, refill
// and the core response channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*, mem_bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,
  input  wire addr_t ar_addr_i,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  output word_t      r_data_o,
  output resp_t      r_resp_o,
  input  wire logic  aw_valid_i,
  output logic       aw_ready_o,
  input  wire addr_t aw_addr_i,
  input  wire logic  w_valid_i,
  output logic       w_ready_o,
  input  wire word_t w_data_i,
  input  wire strb_t w_strb_i,
  output logic       b_valid_o,
  input  wire logic  b_ready_i,
  output resp_t      b_resp_o,
  output logic       mem_ar_valid_o,
  input  wire logic  mem_ar_ready_i,
  output addr_t      mem_ar_addr_o,
  input  wire logic  mem_r_valid_i,
  output logic       mem_r_ready_o,
  input  wire word_t mem_r_data_i,
  input  wire resp_t mem_r_resp_i,
  output logic       mem_aw_valid_o,
  input  wire logic  mem_aw_ready_i,
  output addr_t      mem_aw_addr_o,
  output logic       mem_w_valid_o,
  input  wire logic  mem_w_ready_i,
  output word_t      mem_w_data_o,
  output strb_t      mem_w_strb_o,
  input  wire logic  mem_b_valid_i,
  output logic       mem_b_ready_o,
  input  wire resp_t mem_b_resp_i,
  dcache_tag_if.ctrl  tag,
  dcache_data_if.ctrl data
);

  dcache_state_e state_q;
  addr_t  req_addr_q;
  logic   is_write_q;
  way_t   way_q;    // hit way or chosen victim
  tag_t   wb_tag_q;
  resp_t  resp_q;
  resp_t  refill_resp;
  word_t  w_data_q;
  strb_t  w_strb_q;
  tag_t   req_tag;
  index_t req_index;
  logic   ar_hs, aw_hs, w_hs;
  logic   mem_ar_hs, mem_r_hs, mem_aw_hs, mem_w_hs, mem_b_hs;
  logic   write_commit;

  assign req_tag   = req_addr_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
  assign req_index = req_addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

  assign ar_ready_o     = (state_q == idle);
  assign aw_ready_o     = (state_q == idle) && !ar_valid_i; // reads go first
  assign mem_ar_valid_o = (state_q == refill_addr);
  assign mem_ar_addr_o  = {req_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == refill_data);
  assign mem_aw_valid_o = (state_q == write_back_addr);
  assign mem_aw_addr_o  = {wb_tag_q, req_index, {`DCACHE_OFFSET_W{1'b0}}};
  assign mem_w_valid_o  = (state_q == write_back_data);
  assign mem_w_data_o   = data.rdata; // victim word, RAM output holds until next read
  assign mem_w_strb_o   = '1;
  assign mem_b_ready_o  = (state_q == write_back_resp);

  assign ar_hs     = ar_valid_i && ar_ready_o;
  assign aw_hs     = aw_valid_i && aw_ready_o;
  assign w_hs      = w_valid_i && w_ready_o;
  assign mem_ar_hs = mem_ar_valid_o && mem_ar_ready_i;
  assign mem_r_hs  = mem_r_valid_i && mem_r_ready_o;
  assign mem_aw_hs = mem_aw_valid_o && mem_aw_ready_i;
  assign mem_w_hs  = mem_w_valid_o && mem_w_ready_i;
  assign mem_b_hs  = mem_b_valid_i && mem_b_ready_o;

  // second write_data cycle merges the captured bytes
  assign write_commit = (state_q == write_data) && !w_ready_o;
  assign refill_resp  = (resp_q != `DCACHE_RESP_OKAY) ? resp_q : mem_r_resp_i;

  assign tag.lookup_index = req_index;
  assign tag.lookup_tag   = req_tag;
  assign tag.update_en    = mem_r_hs; // install on refill
  assign tag.update_way   = way_q;
  assign tag.update_tag   = req_tag;
  assign tag.update_valid = 1'b1;
  assign tag.set_dirty    = write_commit;
  assign tag.clear_dirty  = mem_r_hs;

  always_comb begin
    data.en    = 1'b0;
    data.we    = 1'b0;
    data.way   = way_q;
    data.index = req_index;
    data.wdata = mem_r_data_i;
    data.strb  = '1;
    case (state_q)
      lookup: begin
        data.en  = 1'b1; // hit word or victim word
        data.way = tag.hit ? tag.hit_way : tag.victim_way;
      end
      refill_data: begin
        data.en = mem_r_hs;
        data.we = mem_r_hs;
      end
      write_data: begin
        data.en    = write_commit;
        data.we    = write_commit;
        data.wdata = w_data_q;
        data.strb  = w_strb_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= idle;
      w_ready_o <= 1'b0;
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      case (state_q)
        idle: if (ar_hs || aw_hs) state_q <= lookup;
        lookup: begin
          if (tag.hit && is_write_q) begin
            w_ready_o <= 1'b1;
            state_q   <= write_data;
          end else if (tag.hit) begin
            state_q <= respond;
          end else if (tag.victim_dirty) begin
            state_q <= write_back_addr;
          end else begin
            state_q <= refill_addr;
          end
        end
        write_back_addr: if (mem_aw_hs) state_q <= write_back_data;
        write_back_data: if (mem_w_hs) state_q <= write_back_resp;
        write_back_resp: if (mem_b_hs) state_q <= refill_addr;
        refill_addr:     if (mem_ar_hs) state_q <= refill_data;
        refill_data: begin
          if (mem_r_hs && is_write_q) begin
            w_ready_o <= 1'b1;
            state_q   <= write_data;
          end else if (mem_r_hs) begin
            r_valid_o <= 1'b1; // refill word goes straight out
            state_q   <= respond;
          end
        end
        write_data: begin
          if (w_hs) w_ready_o <= 1'b0;
          else if (!w_ready_o) state_q <= respond;
        end
        respond: begin
          if (is_write_q) begin
            if (!b_valid_o) begin
              b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
              b_valid_o <= 1'b0;
              state_q   <= idle;
            end
          end else begin
            if (!r_valid_o) begin
              r_valid_o <= 1'b1;
            end else if (r_ready_i) begin
              r_valid_o <= 1'b0;
              state_q   <= idle;
            end
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state_q)
      idle: begin
        if (ar_hs) begin
          req_addr_q <= ar_addr_i;
          is_write_q <= 1'b0;
        end else if (aw_hs) begin
          req_addr_q <= aw_addr_i;
          is_write_q <= 1'b1;
        end
      end
      lookup: begin
        way_q    <= tag.hit ? tag.hit_way : tag.victim_way;
        wb_tag_q <= tag.victim_tag;
        resp_q   <= `DCACHE_RESP_OKAY;
      end
      write_back_resp: if (mem_b_hs) resp_q <= mem_b_resp_i;
      refill_data: begin
        if (mem_r_hs) begin
          resp_q   <= refill_resp;
          r_data_o <= mem_r_data_i;
          r_resp_o <= refill_resp;
        end
      end
      write_data: begin
        if (w_hs) begin
          w_data_q <= w_data_i;
          w_strb_q <= w_strb_i;
        end
      end
      respond: begin
        if (!is_write_q && !r_valid_o) begin
          r_data_o <= data.rdata;
          r_resp_o <= resp_q;
        end
        if (is_write_q && !b_valid_o) b_resp_o <= resp_q;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/dcache_data_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache data array
// one word RAM per way, byte writes, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_array import dcache_pkg::*, mem_bus_pkg::*; (
  input  wire logic    clk,
  dcache_data_if.array data
);

  word_t rd_word [`DCACHE_WAYS];
  way_t  rd_way_q; // way of the last read, picks the output

  for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
    word_t ram_q [`DCACHE_SETS];
    word_t rd_q;
    logic  sel;

    assign sel        = data.en && (data.way == way_t'(w));
    assign rd_word[w] = rd_q;

    always_ff @(posedge clk) begin
      if (sel) begin
        if (data.we) begin
          for (int b = 0; b < `DCACHE_DATA_W / 8; b++) begin
            if (data.strb[b]) ram_q[data.index][b*8 +: 8] <= data.wdata[b*8 +: 8];
          end
        end else begin
          rd_q <= ram_q[data.index];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data.en && !data.we) rd_way_q <= data.way;
  end

  assign data.rdata = rd_word[rd_way_q];

endmodule

`default_nettype wire

/* logic/dcache_data_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller to data array link
// rdata follows en by one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface dcache_data_if import dcache_pkg::*, mem_bus_pkg::*; ();
  logic   en;
  logic   we;
  way_t   way;
  index_t index;
  word_t  wdata;
  strb_t  strb;
  word_t  rdata;

  modport ctrl (
    output en, we, way, index, wdata, strb,
    input  rdata
  );

  modport array (
    input  en, we, way, index, wdata, strb,
    output rdata
  );
endinterface

`default_nettype wire

/* logic/dcache_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache geometry and codes
// address split, way count, data width, bus response codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DCACHE_ADDR_W    32
`define DCACHE_TAG_W     23
`define DCACHE_INDEX_W   6
`define DCACHE_OFFSET_W  3 // byte offset in a word
`define DCACHE_SETS      64
`define DCACHE_WAYS      2
`define DCACHE_DATA_W    64

`define DCACHE_RESP_OKAY 2'd0

`endif

/* logic/dcache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache cache-side types
// tag, index and way vectors, controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  typedef logic [`DCACHE_TAG_W-1:0]          tag_t;
  typedef logic [`DCACHE_INDEX_W-1:0]        index_t;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0]   way_t;

  typedef enum logic [3:0] {
    idle,
    lookup,
    write_data,
    write_back_addr,
    write_back_data,
    write_back_resp,
    refill_addr,
    refill_data,
    respond
  } dcache_state_e;

endpackage

`default_nettype wire

/* logic/dcache_tag_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller to tag store link
// combinational lookup, updates on the clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface dcache_tag_if import dcache_pkg::*; ();
  index_t lookup_index;
  tag_t   lookup_tag;
  logic   update_en;
  way_t   update_way;
  tag_t   update_tag;
  logic   update_valid;
  logic   set_dirty;
  logic   clear_dirty;

  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  tag_t   victim_tag;
  logic   victim_dirty;

  modport ctrl (
    output lookup_index, lookup_tag, update_en, update_way, update_tag,
    output update_valid, set_dirty, clear_dirty,
    input  hit, hit_way, victim_way, victim_tag, victim_dirty
  );

  modport store (
    input  lookup_index, lookup_tag, update_en, update_way, update_tag,
    input  update_valid, set_dirty, clear_dirty,
    output hit, hit_way, victim_way, victim_tag, victim_dirty
  );
endinterface

`default_nettype wire

/* logic/dcache_tag_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache tag store
// tag, valid and dirty per way and set
// hit detect and victim pick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_store import dcache_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst,
  dcache_tag_if.store tag
);

  tag_t                                tag_q [`DCACHE_WAYS][`DCACHE_SETS];
  logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_q;
  logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] dirty_q;
  way_t                                repl_q; // free-running replacement pointer
  logic [`DCACHE_WAYS-1:0]             hit_vec;
  way_t                                hit_way;
  way_t                                victim;

  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    victim  = repl_q;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      hit_vec[w] = valid_q[w][tag.lookup_index] && (tag_q[w][tag.lookup_index] == tag.lookup_tag);
      if (hit_vec[w]) hit_way = way_t'(w);
    end
    // lowest invalid way wins over the pointer
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][tag.lookup_index]) victim = way_t'(w);
    end
  end

  assign tag.hit          = |hit_vec;
  assign tag.hit_way      = hit_way;
  assign tag.victim_way   = victim;
  assign tag.victim_tag   = tag_q[victim][tag.lookup_index];
  assign tag.victim_dirty = valid_q[victim][tag.lookup_index] && dirty_q[victim][tag.lookup_index];

  always_ff @(posedge clk) begin
    if (tag.update_en) tag_q[tag.update_way][tag.lookup_index] <= tag.update_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      repl_q  <= '0;
    end else begin
      repl_q <= repl_q + 1'b1;
      if (tag.update_en) valid_q[tag.update_way][tag.lookup_index] <= tag.update_valid;
      if (tag.set_dirty) begin
        dirty_q[tag.update_way][tag.lookup_index] <= 1'b1;
      end else if (tag.clear_dirty) begin
        dirty_q[tag.update_way][tag.lookup_index] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache top level
// controller, tag store and data array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dcache_top import mem_bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,
  input  wire addr_t ar_addr_i,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  output word_t      r_data_o,
  output resp_t      r_resp_o,
  input  wire logic  aw_valid_i,
  output logic       aw_ready_o,
  input  wire addr_t aw_addr_i,
  input  wire logic  w_valid_i,
  output logic       w_ready_o,
  input  wire word_t w_data_i,
  input  wire strb_t w_strb_i,
  output logic       b_valid_o,
  input  wire logic  b_ready_i,
  output resp_t      b_resp_o,
  output logic       mem_ar_valid_o,
  input  wire logic  mem_ar_ready_i,
  output addr_t      mem_ar_addr_o,
  input  wire logic  mem_r_valid_i,
  output logic       mem_r_ready_o,
  input  wire word_t mem_r_data_i,
  input  wire resp_t mem_r_resp_i,
  output logic       mem_aw_valid_o,
  input  wire logic  mem_aw_ready_i,
  output addr_t      mem_aw_addr_o,
  output logic       mem_w_valid_o,
  input  wire logic  mem_w_ready_i,
  output word_t      mem_w_data_o,
  output strb_t      mem_w_strb_o,
  input  wire logic  mem_b_valid_i,
  output logic       mem_b_ready_o,
  input  wire resp_t mem_b_resp_i
);

  dcache_tag_if  tag_if ();
  dcache_data_if data_if ();

  // all core and memory channels pass by name
  dcache_ctrl u_ctrl (
    .*,
    .tag  (tag_if.ctrl),
    .data (data_if.ctrl)
  );

  dcache_tag_store u_tag_store (
    .clk (clk),
    .rst (rst),
    .tag (tag_if.store)
  );

  dcache_data_array u_data_array (
    .clk  (clk),
    .data (data_if.array)
  );

endmodule

`default_nettype wire

/* logic/mem_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus-side types for core and memory channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dcache_defs.svh"

package mem_bus_pkg;
  typedef logic [`DCACHE_ADDR_W-1:0]   addr_t;
  typedef logic [`DCACHE_DATA_W-1:0]   word_t;
  typedef logic [`DCACHE_DATA_W/8-1:0] strb_t;
  typedef logic [1:0]                  resp_t;
endpackage

`default_nettype wire

/* tb.f */
+incdir+logic
logic/dcache_pkg.sv
logic/mem_bus_pkg.sv
logic/dcache_tag_if.sv
logic/dcache_data_if.sv
logic/dcache_tag_store.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/tb_dcache.sv
